//--- project.f
common/permPkg.sv
permutationGenerator/permutationGenerator.sv
coeffPipeline/resultFifo.sv
coeffPipeline/coeffPipeline.sv
hdl/resultRegister.sv
hdl/permutationTop.sv
verification/clockGen.sv
verification/permutationTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the permutation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module permutationTb -f project.f -o simPermutation
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simPermutation 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "all tests passed" <<< "$output"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

//--- verification/permutationTb.sv
`timescale 1ns/1ns

module permutationTb import permPkg::*; ();

    localparam int fifoDepth = 4;
    localparam int grabDelay = 6;
    localparam int numDirected = 6;
    localparam int numRandom = 40;
    localparam int numStalled = 6; // upper bound on bots taken during the stall
    localparam int numPerTop = 10;
    localparam int numTops = 2;
    localparam int numBots = numDirected + numRandom + numStalled + numPerTop * numTops;
    localparam int cycleLimit = numBots * (numPerms + grabDelay + 12) + 200;

    logic clk;
    logic arstN;
    truthTable_t top;
    truthTable_t bot;
    logic writeBot;
    logic readyForInputBot;
    logic grabResults;
    logic resultsAvailable;
    coeffSum_t coeffSum;
    coeffCount_t coeffCount;

    logic [31:0] lfsrState;
    coeffSum_t expSumQ[$];
    coeffCount_t expCountQ[$];
    logic grabEnable;
    int cycleCount;

    clockGen #(
        .periodNs(8),
        .resetCycles(4)
    ) clockReset (
        .clk(clk),
        .arstN(arstN)
    );

    permutationTop #(
        .fifoDepth(fifoDepth),
        .grabDelay(grabDelay)
    ) DUT (
        .clk(clk),
        .arstN(arstN),
        .top(top),
        .bot(bot),
        .writeBot(writeBot),
        .readyForInputBot(readyForInputBot),
        .grabResults(grabResults),
        .resultsAvailable(resultsAvailable),
        .coeffSum(coeffSum),
        .coeffCount(coeffCount)
    );

    // galois lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
        return bits;
    endfunction

    function automatic truthTable_t randomTable();
        logic [31:0] r;
        r = randomBits(ttWidth);
        return r[ttWidth-1:0];
    endfunction

    // about half the bots are pushed towards subsets of top
    function automatic truthTable_t randomBot(input truthTable_t topTt);
        truthTable_t b;
        b = randomTable();
        if (randomBits(1) == 32'd1) begin
            b = b & topTt;
        end
        return b;
    endfunction

    function automatic int onesIn(input truthTable_t tt);
        int n;
        n = 0;
        for (int i = 0; i < ttWidth; i++) begin
            if (tt[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // sum and count over every order of variables 1..3 in any visiting order
    function automatic void referenceResult(
        input  truthTable_t topTt,
        input  truthTable_t botTt,
        output coeffSum_t   sum,
        output coeffCount_t count
    );
        int order[4];
        logic [3:0] idx;
        logic [3:0] src;
        truthTable_t permuted;
        sum = '0;
        count = '0;
        for (int a = 1; a <= 3; a++) begin
            for (int b = 1; b <= 3; b++) begin
                for (int c = 1; c <= 3; c++) begin
                    if (a != b && b != c && a != c) begin
                        order = '{0, a, b, c};
                        for (int i = 0; i < ttWidth; i++) begin
                            idx = 4'(i);
                            for (int k = 0; k < 4; k++) begin
                                src[order[k]] = idx[k];
                            end
                            permuted[i] = botTt[src];
                        end
                        if ((permuted & ~topTt) == '0) begin
                            count = count + coeffCount_t'(1);
                            sum = sum + (coeffSum_t'(1) << onesIn(topTt & ~permuted));
                        end
                    end
                end
            end
        end
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkSum(input coeffSum_t expected, input coeffSum_t received);
        if (received !== expected) begin
            $display("Fail at %0t ns: coeffSum expected %0d received %0d",
                     $time, expected, received);
            failRun("wrong coefficient sum");
        end
    endtask

    task automatic checkCount(input coeffCount_t expected, input coeffCount_t received);
        if (received !== expected) begin
            $display("Fail at %0t ns: coeffCount expected %0d received %0d",
                     $time, expected, received);
            failRun("wrong permutation count");
        end
    endtask

    task automatic checkBit(input logic expected, input logic received, input string what);
        if (received !== expected) begin
            $display("Fail at %0t ns: %s expected %b received %b",
                     $time, what, expected, received);
            failRun("wrong status flag");
        end
    endtask

    task automatic writeWhenReady(
        input truthTable_t b,
        input coeffSum_t   expSum,
        input coeffCount_t expCount
    );
        while (!readyForInputBot) begin
            @(posedge clk);
            #1;
        end
        bot = b;
        writeBot = 1'b1;
        expSumQ.push_back(expSum);
        expCountQ.push_back(expCount);
        @(posedge clk);
        #1;
        writeBot = 1'b0;
    endtask

    task automatic writeWithReference(input truthTable_t b);
        coeffSum_t s;
        coeffCount_t c;
        referenceResult(top, b, s, c);
        writeWhenReady(b, s, c);
    endtask

    // top may only change once nothing is in flight
    task automatic waitDrain();
        while (expSumQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : compareResults
        coeffSum_t expSum;
        coeffCount_t expCount;
        grabResults = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            grabResults = 1'b0;
            if (resultsAvailable && grabEnable) begin
                if (expSumQ.size() == 0) begin
                    failRun("a result arrived with no bot written for it");
                end else begin
                    expSum = expSumQ.pop_front();
                    expCount = expCountQ.pop_front();
                    checkSum(expSum, coeffSum);
                    checkCount(expCount, coeffCount);
                    grabResults = 1'b1; // take it at once
                end
            end
        end
    end

    initial begin : watchdog
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                failRun($sformatf("run did not finish within %0d cycles", cycleLimit));
            end
        end
    end

    initial begin : stimulus
        int stallCycles;
        top = '0;
        bot = '0;
        writeBot = 1'b0;
        grabEnable = 1'b1;
        lfsrState = 32'd83995;
        @(posedge arstN);
        @(posedge clk);
        #1;
        checkBit(1'b1, readyForInputBot, "readyForInputBot after reset");
        checkBit(1'b0, resultsAvailable, "resultsAvailable after reset");

        // empty bot fits any top
        top = randomTable();
        writeWhenReady('0, coeffSum_t'(numPerms) << onesIn(top), coeffCount_t'(numPerms));
        waitDrain();

        // minterms 0 and 15 are fixed by every permutation
        top = 16'hFFFE;
        writeWhenReady(16'h0001, '0, '0);
        writeWhenReady(16'h8001, '0, '0);
        writeWhenReady(16'h8000, coeffSum_t'(6) << 14, coeffCount_t'(6));
        writeWhenReady(16'hC000, coeffSum_t'(6) << 13, coeffCount_t'(6));
        writeWhenReady(16'h0114, coeffSum_t'(6) << 12, coeffCount_t'(6));
        waitDrain();

        top = randomTable();
        repeat (numRandom) begin
            writeWithReference(randomBot(top));
        end
        waitDrain();

        // hold the output register so the queue backs up
        grabEnable = 1'b0;
        stallCycles = 0;
        while (stallCycles < 100) begin
            if (readyForInputBot) begin
                writeWithReference(randomBot(top));
            end else begin
                @(posedge clk);
                #1;
            end
            stallCycles++;
        end
        // generator goes idle here, only the full queue holds input back
        repeat (numPerms) begin
            @(posedge clk);
            #1;
        end
        checkBit(1'b0, readyForInputBot, "readyForInputBot while results are held");
        grabEnable = 1'b1;
        waitDrain();

        repeat (numTops) begin
            top = randomTable();
            repeat (numPerTop) begin
                writeWithReference(randomBot(top));
            end
            waitDrain();
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- verification/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int periodNs = 8,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // release just after an edge, away from the sampling point
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
    end

endmodule

//--- hdl/permutationTop.sv
`timescale 1ns/1ns

module permutationTop import permPkg::*; #(
    parameter int fifoDepth = 4,
    parameter int grabDelay = 6
) (
    input  logic        clk,
    input  logic        arstN,

    input  truthTable_t top,

    input  truthTable_t bot,
    input  logic        writeBot,
    output logic        readyForInputBot,

    input  logic        grabResults,
    output logic        resultsAvailable,
    output coeffSum_t   coeffSum,
    output coeffCount_t coeffCount
);

    localparam int spacingWidth = $clog2(grabDelay + 1);

    truthTable_t permutedBot;
    logic permutedBotValid;
    logic batchDone;
    logic pipelineSlowDown;
    logic generatorHasSpace;

    logic grabNewResult;
    logic pipelineResultAvailable;
    coeffSum_t pipeSum;
    coeffCount_t pipeCount;

    logic [spacingWidth-1:0] cyclesSinceGrab;
    logic readyForGrab;
    logic [grabDelay-1:0] grabLine;

    assign readyForInputBot = generatorHasSpace && !pipelineSlowDown;

    permutationGenerator permGen (
        .clk(clk),
        .arstN(arstN),
        .inBot(bot),
        .writeInBot(writeBot),
        .hasSpace(generatorHasSpace),
        .outBot(permutedBot),
        .outBotValid(permutedBotValid),
        .botSeriesFinished(batchDone)
    );

    coeffPipeline #(
        .fifoDepth(fifoDepth)
    ) computePipe (
        .clk(clk),
        .arstN(arstN),
        .top(top),
        .bot(permutedBot),
        .isBotValid(permutedBotValid),
        .batchDone(batchDone),
        .slowDownInput(pipelineSlowDown),
        .grabResults(grabNewResult),
        .resultsAvailable(pipelineResultAvailable),
        .coeffSum(pipeSum),
        .coeffCount(pipeCount)
    );

    // saturates at grabDelay, so grabs are at least grabDelay+1 cycles apart
    assign readyForGrab = cyclesSinceGrab == spacingWidth'(grabDelay);
    assign grabNewResult = !resultsAvailable && pipelineResultAvailable && readyForGrab;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cyclesSinceGrab <= spacingWidth'(grabDelay);
            grabLine <= '0;
        end else begin
            if (grabNewResult) begin
                cyclesSinceGrab <= '0;
            end else if (!readyForGrab) begin
                cyclesSinceGrab <= cyclesSinceGrab + 1'b1;
            end
            grabLine <= {grabLine[grabDelay-2:0], grabNewResult}; // strobe delay line
        end
    end

    resultRegister outputReg (
        .clk(clk),
        .arstN(arstN),
        .write(grabLine[grabDelay-1]),
        .dataSum(pipeSum),
        .dataCount(pipeCount),
        .grab(grabResults),
        .hasData(resultsAvailable),
        .sum(coeffSum),
        .count(coeffCount)
    );

endmodule

//--- hdl/resultRegister.sv
`timescale 1ns/1ns

module resultRegister import permPkg::*; (
    input  logic        clk,
    input  logic        arstN,

    input  logic        write,
    input  coeffSum_t   dataSum,
    input  coeffCount_t dataCount,

    input  logic        grab,
    output logic        hasData,
    output coeffSum_t   sum,
    output coeffCount_t count
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hasData <= 1'b0;
        end else if (write) begin
            hasData <= 1'b1;
        end else if (grab) begin
            hasData <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            sum <= dataSum;
            count <= dataCount;
        end
    end

endmodule

//--- coeffPipeline/coeffPipeline.sv
`timescale 1ns/1ns

module coeffPipeline import permPkg::*; #(
    parameter int fifoDepth = 4
) (
    input  logic        clk,
    input  logic        arstN,

    input  truthTable_t top,
    input  truthTable_t bot,
    input  logic        isBotValid,
    input  logic        batchDone,
    output logic        slowDownInput,

    input  logic        grabResults,
    output logic        resultsAvailable,
    output coeffSum_t   coeffSum,
    output coeffCount_t coeffCount
);

    logic s1Valid;
    logic s1Last;
    logic s1Flag;
    logic [4:0] s1Pop;

    logic s2Valid;
    logic s2Last;
    logic s2Flag;
    coeffSum_t s2Term;

    coeffSum_t sumAcc;
    coeffCount_t countAcc;
    logic pushValid;
    coeffSum_t pushSum;
    coeffCount_t pushCount;

    // valid and batch markers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            s1Last <= 1'b0;
            s2Valid <= 1'b0;
            s2Last <= 1'b0;
        end else begin
            s1Valid <= isBotValid;
            s1Last <= isBotValid && batchDone;
            s2Valid <= s1Valid;
            s2Last <= s1Last;
        end
    end

    always_ff @(posedge clk) begin
        s1Flag <= (bot & ~top) == '0; // subset of top
        s1Pop <= 5'($countones(top & ~bot));
        s2Flag <= s1Flag;
        s2Term <= s1Flag ? (coeffSum_t'(1) << s1Pop) : '0;
    end

    // stage 3, running totals
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sumAcc <= '0;
            countAcc <= '0;
            pushValid <= 1'b0;
        end else begin
            pushValid <= s2Valid && s2Last;
            if (s2Valid) begin
                if (s2Last) begin
                    sumAcc <= '0;
                    countAcc <= '0;
                end else begin
                    sumAcc <= sumAcc + s2Term;
                    countAcc <= countAcc + coeffCount_t'(s2Flag);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2Valid && s2Last) begin
            pushSum <= sumAcc + s2Term;
            pushCount <= countAcc + coeffCount_t'(s2Flag);
        end
    end

    resultFifo #(
        .fifoDepth(fifoDepth)
    ) resultQueue (
        .clk(clk),
        .arstN(arstN),
        .push(pushValid),
        .pushSum(pushSum),
        .pushCount(pushCount),
        .pop(grabResults),
        .notEmpty(resultsAvailable),
        .almostFull(slowDownInput),
        .headSum(coeffSum),
        .headCount(coeffCount)
    );

endmodule

//--- coeffPipeline/resultFifo.sv
`timescale 1ns/1ns

module resultFifo import permPkg::*; #(
    parameter int fifoDepth = 4
) (
    input  logic        clk,
    input  logic        arstN,

    input  logic        push,
    input  coeffSum_t   pushSum,
    input  coeffCount_t pushCount,

    input  logic        pop,
    output logic        notEmpty,
    output logic        almostFull,
    output coeffSum_t   headSum,
    output coeffCount_t headCount
);

    localparam int ptrWidth = fifoDepth > 1 ? $clog2(fifoDepth) : 1;
    localparam int cntWidth = $clog2(fifoDepth + 1);

    coeffSum_t sumMem [fifoDepth];
    coeffCount_t countMem [fifoDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] used;
    logic doPop;

    assign notEmpty = used != '0;
    // room left for one batch in the pipe and one just accepted
    assign almostFull = used >= cntWidth'(fifoDepth - 2);
    assign doPop = pop && notEmpty;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrWidth'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == ptrWidth'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !doPop) begin
                used <= used + 1'b1;
            end else if (doPop && !push) begin
                used <= used - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            sumMem[wrPtr] <= pushSum;
            countMem[wrPtr] <= pushCount;
        end
        if (doPop) begin
            headSum <= sumMem[rdPtr]; // holds until the next pop
            headCount <= countMem[rdPtr];
        end
    end

endmodule

//--- permutationGenerator/permutationGenerator.sv
`timescale 1ns/1ns

module permutationGenerator import permPkg::*; (
    input  logic        clk,
    input  logic        arstN,

    input  truthTable_t inBot,
    input  logic        writeInBot,
    output logic        hasSpace,

    output truthTable_t outBot,
    output logic        outBotValid,
    output logic        botSeriesFinished
);

    logic [2:0] step;
    logic lastStep;
    truthTable_t swapped12;
    truthTable_t swapped23;

    // rearranges the table as if variables a and b traded places
    function automatic truthTable_t swapVars(
        input truthTable_t tt,
        input int          a,
        input int          b
    );
        truthTable_t res;
        logic [3:0] src;
        for (int i = 0; i < ttWidth; i++) begin
            src = 4'(i);
            src[a] = i[b];
            src[b] = i[a];
            res[i] = tt[src];
        end
        return res;
    endfunction

    assign lastStep = step == 3'(numPerms - 1);

    assign swapped12 = swapVars(outBot, 1, 2);
    assign swapped23 = swapVars(outBot, 2, 3);

    // the last emission frees the slot, so batches can run back to back
    assign hasSpace = !outBotValid || lastStep;
    assign botSeriesFinished = outBotValid && lastStep;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outBotValid <= 1'b0;
            step <= '0;
        end else if (writeInBot) begin
            outBotValid <= 1'b1;
            step <= '0;
        end else if (outBotValid) begin
            if (lastStep) begin
                outBotValid <= 1'b0;
            end else begin
                step <= step + 3'd1;
            end
        end
    end

    // Steinhaus-Johnson-Trotter over variables 1..3:
    // identity, then swap (1,2), (2,3), (1,2), (2,3), (1,2)
    always_ff @(posedge clk) begin
        if (writeInBot) begin
            outBot <= inBot;
        end else if (outBotValid && !lastStep) begin
            outBot <= step[0] ? swapped23 : swapped12; // even step swaps 1 and 2
        end
    end

endmodule

//--- common/permPkg.sv
package permPkg;

    // one truth table over four variables, bit index is {x3, x2, x1, x0}
    localparam int ttWidth = 16;

    // six times 2^16 still fits
    localparam int sumWidth = 24;

    // 0 to numPerms
    localparam int countWidth = 4;

    // permutations of variables 1..3, variable 0 stays put
    localparam int numPerms = 6;

    typedef logic [ttWidth-1:0] truthTable_t;
    typedef logic [sumWidth-1:0] coeffSum_t;
    typedef logic [countWidth-1:0] coeffCount_t;

endpackage
